// File: rtl/soc_bus_pkg.sv
package soc_bus_pkg;

    // Master bus widths.
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;

    // The top address nibble selects the region.
    localparam int REGION_HI = 31;
    localparam int REGION_LO = 28;
    localparam int REGION_W  = REGION_HI - REGION_LO + 1;

    localparam logic [REGION_W-1:0] REGION_RAM  = 'h0;
    localparam logic [REGION_W-1:0] REGION_ROM  = 'h1;
    localparam logic [REGION_W-1:0] REGION_GPIO = 'h2;

    // SSRAM byte address width.
    localparam int RAM_ADDR_W = 24;

    // Boot ROM geometry, one entry per 32-bit word.
    localparam int ROM_WORDS = 16;
    localparam int ROM_IDX_W = 4;

    // GPIO register map.
    localparam int GPIO_ADDR_W = 8;
    localparam logic [GPIO_ADDR_W-1:0] GPIO_OUT_OFS = 'h00;
    localparam logic [GPIO_ADDR_W-1:0] GPIO_IN_OFS  = 'h04;

    // Clocks from the address leaving the controller to the data being sampled.
    localparam int SSRAM_RD_LAT = 2;
    localparam int RD_CNT_W     = $clog2(SSRAM_RD_LAT + 1);

    // Value seen by the master when it reads a hole in the map.
    localparam logic [DATA_W-1:0] UNMAPPED_DATA = '0;

endpackage

// File: rtl/dbus.sv
module dbus (
    input  logic                                clk,
    input  logic                                rst_n_i,

    input  logic                                bus_read_i,
    input  logic                                bus_write_i,
    input  logic [soc_bus_pkg::ADDR_W-1:0]      bus_address_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]      bus_wrdata_i,
    input  logic [soc_bus_pkg::BE_W-1:0]        bus_byteenable_i,
    output logic [soc_bus_pkg::DATA_W-1:0]      bus_rddata_o,
    output logic                                bus_stall_o,

    output logic                                ram_rd_o,
    output logic                                ram_wr_o,
    output logic [soc_bus_pkg::RAM_ADDR_W-1:0]  ram_address_o,
    output logic [soc_bus_pkg::DATA_W-1:0]      ram_wrdata_o,
    output logic [soc_bus_pkg::BE_W-1:0]        ram_be_o,
    input  logic [soc_bus_pkg::DATA_W-1:0]      ram_rddata_i,
    input  logic                                ram_busy_i,

    output logic [soc_bus_pkg::ROM_IDX_W-1:0]   rom_index_o,
    input  logic [soc_bus_pkg::DATA_W-1:0]      rom_data_i,

    output logic                                gpio_rd_o,
    output logic                                gpio_wr_o,
    output logic [soc_bus_pkg::GPIO_ADDR_W-1:0] gpio_offset_o,
    output logic [soc_bus_pkg::DATA_W-1:0]      gpio_wrdata_o,
    output logic [soc_bus_pkg::BE_W-1:0]        gpio_be_o,
    input  logic [soc_bus_pkg::DATA_W-1:0]      gpio_rddata_i
);
    import soc_bus_pkg::*;

    logic [REGION_W-1:0] region;
    logic                sel_ram;
    logic                sel_rom;
    logic                sel_gpio;
    logic                rom_wait_q;
    logic                rom_stall;

    assign region   = bus_address_i[REGION_HI:REGION_LO];
    assign sel_ram  = (region == REGION_RAM);
    assign sel_rom  = (region == REGION_ROM);
    assign sel_gpio = (region == REGION_GPIO);

    assign ram_rd_o      = bus_read_i & sel_ram;
    assign ram_wr_o      = bus_write_i & sel_ram;
    assign ram_address_o = bus_address_i[RAM_ADDR_W-1:0];
    assign ram_wrdata_o  = bus_wrdata_i;
    assign ram_be_o      = bus_byteenable_i;

    // The ROM is word addressed.
    assign rom_index_o = bus_address_i[ROM_IDX_W+1:2];

    assign gpio_rd_o     = bus_read_i & sel_gpio;
    assign gpio_wr_o     = bus_write_i & sel_gpio;
    assign gpio_offset_o = bus_address_i[GPIO_ADDR_W-1:0];
    assign gpio_wrdata_o = bus_wrdata_i;
    assign gpio_be_o     = bus_byteenable_i;

    // A ROM read stalls once while the registered array output settles.
    // Writes to the ROM fall through with no wait and no effect.
    assign rom_stall = bus_read_i & sel_rom & ~rom_wait_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rom_wait_q <= 1'b0;
        end else begin
            rom_wait_q <= rom_stall;
        end
    end

    assign bus_stall_o = ram_busy_i | rom_stall;

    always_comb begin
        case (region)
            REGION_RAM:  bus_rddata_o = ram_rddata_i;
            REGION_ROM:  bus_rddata_o = rom_data_i;
            REGION_GPIO: bus_rddata_o = gpio_rddata_i;
            default:     bus_rddata_o = UNMAPPED_DATA;
        endcase
    end

    a_one_strobe: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(bus_read_i && bus_write_i)
    );

    // The master must not move the address under a stalled access.
    a_addr_held: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (bus_read_i || bus_write_i) && bus_stall_o |=> $stable(bus_address_i)
    );

endmodule

// File: rtl/ssram_ctl.sv
module ssram_ctl (
    input  logic                               clk,
    input  logic                               rst_n_i,

    input  logic                               rd_i,
    input  logic                               wr_i,
    input  logic [soc_bus_pkg::RAM_ADDR_W-1:0] address_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]     wrdata_i,
    input  logic [soc_bus_pkg::BE_W-1:0]       be_i,
    output logic [soc_bus_pkg::DATA_W-1:0]     rddata_o,
    output logic                               busy_o,

    output logic [soc_bus_pkg::RAM_ADDR_W-1:0] ssram_addr_o,
    output logic [soc_bus_pkg::DATA_W-1:0]     ssram_data_o,
    output logic                               ssram_data_oe_o,
    input  logic [soc_bus_pkg::DATA_W-1:0]     ssram_data_i,
    output logic [soc_bus_pkg::BE_W-1:0]       ssram_be_n_o,
    output logic                               ssram_ce_n_o,
    output logic                               ssram_we_n_o,
    output logic                               ssram_oe_n_o
);
    import soc_bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_RD_WAIT,
        ST_RD_DONE
    } state_e;

    state_e              state_q;
    logic [RD_CNT_W-1:0] lat_cnt_q;
    logic                start;
    logic                lat_done;

    assign start    = (state_q == ST_IDLE) && (rd_i || wr_i);
    assign lat_done = (lat_cnt_q == RD_CNT_W'(SSRAM_RD_LAT - 1));
    assign busy_o   = start || (state_q == ST_RD_WAIT);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q         <= ST_IDLE;
            lat_cnt_q       <= '0;
            ssram_ce_n_o    <= 1'b1;
            ssram_we_n_o    <= 1'b1;
            ssram_oe_n_o    <= 1'b1;
            ssram_data_oe_o <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    lat_cnt_q <= '0;
                    if (wr_i) begin
                        state_q         <= ST_WRITE;
                        ssram_ce_n_o    <= 1'b0;
                        ssram_we_n_o    <= 1'b0;
                        ssram_data_oe_o <= 1'b1;
                    end else if (rd_i) begin
                        state_q      <= ST_RD_WAIT;
                        ssram_ce_n_o <= 1'b0;
                        ssram_oe_n_o <= 1'b0;
                    end
                end
                // One cycle on the pins is enough for a write.
                ST_WRITE: begin
                    state_q         <= ST_IDLE;
                    ssram_ce_n_o    <= 1'b1;
                    ssram_we_n_o    <= 1'b1;
                    ssram_data_oe_o <= 1'b0;
                end
                ST_RD_WAIT: begin
                    lat_cnt_q <= lat_cnt_q + 1'b1;
                    if (lat_done) begin
                        state_q      <= ST_RD_DONE;
                        ssram_ce_n_o <= 1'b1;
                        ssram_oe_n_o <= 1'b1;
                    end
                end
                ST_RD_DONE: state_q <= ST_IDLE;
                default:    state_q <= ST_IDLE;
            endcase
        end
    end

    // Pin payload is launched on the edge that accepts the strobe.
    // Read data is sampled SSRAM_RD_LAT edges after that launch.
    always_ff @(posedge clk) begin
        if (start) begin
            ssram_addr_o <= address_i;
            ssram_data_o <= wrdata_i;
            ssram_be_n_o <= ~be_i;
        end
        if (state_q == ST_RD_WAIT && lat_done) begin
            rddata_o <= ssram_data_i;
        end
    end

    a_no_we_oe: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(!ssram_we_n_o && !ssram_oe_n_o)
    );

endmodule

// File: rtl/bootrom.sv
module bootrom (
    input  logic                              clk,
    input  logic [soc_bus_pkg::ROM_IDX_W-1:0] index_i,
    output logic [soc_bus_pkg::DATA_W-1:0]    data_o
);
    import soc_bus_pkg::*;

    logic [DATA_W-1:0] rom_mem [ROM_WORDS];

    // Contents come from the boot image in the run directory.
    initial begin
        $readmemh("boot.hex", rom_mem);
    end

    // Registered output, so data follows the index by one clock.
    always_ff @(posedge clk) begin
        data_o <= rom_mem[index_i];
    end

endmodule

// File: rtl/gpio_regs.sv
module gpio_regs (
    input  logic                                clk,
    input  logic                                rst_n_i,

    input  logic                                rd_i,
    input  logic                                wr_i,
    input  logic [soc_bus_pkg::GPIO_ADDR_W-1:0] offset_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]      wrdata_i,
    input  logic [soc_bus_pkg::BE_W-1:0]        be_i,
    output logic [soc_bus_pkg::DATA_W-1:0]      rddata_o,

    output logic [soc_bus_pkg::DATA_W-1:0]      gpio0_o,
    input  logic [soc_bus_pkg::DATA_W-1:0]      gpio1_i
);
    import soc_bus_pkg::*;

    logic [DATA_W-1:0] out_q;
    logic [DATA_W-1:0] in_meta_q;
    logic [DATA_W-1:0] in_sync_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_q <= '0;
        end else if (wr_i && offset_i == GPIO_OUT_OFS) begin
            for (int b = 0; b < BE_W; b++) begin
                if (be_i[b]) begin
                    out_q[b*8 +: 8] <= wrdata_i[b*8 +: 8];
                end
            end
        end
    end

    // The input pins are asynchronous to clk.
    always_ff @(posedge clk) begin
        in_meta_q <= gpio1_i;
        in_sync_q <= in_meta_q;
    end

    always_comb begin
        rddata_o = '0;
        if (rd_i) begin
            case (offset_i)
                GPIO_OUT_OFS: rddata_o = out_q;
                GPIO_IN_OFS:  rddata_o = in_sync_q;
                default:      rddata_o = '0;
            endcase
        end
    end

    assign gpio0_o = out_q;

endmodule

// File: rtl/soc_bus_top.sv
module soc_bus_top (
    input  logic                               clk,
    input  logic                               rst_n_i,

    input  logic                               bus_read_i,
    input  logic                               bus_write_i,
    input  logic [soc_bus_pkg::ADDR_W-1:0]     bus_address_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]     bus_wrdata_i,
    input  logic [soc_bus_pkg::BE_W-1:0]       bus_byteenable_i,
    output logic [soc_bus_pkg::DATA_W-1:0]     bus_rddata_o,
    output logic                               bus_stall_o,

    output logic [soc_bus_pkg::RAM_ADDR_W-1:0] ssram_addr_o,
    output logic [soc_bus_pkg::DATA_W-1:0]     ssram_data_o,
    output logic                               ssram_data_oe_o,
    input  logic [soc_bus_pkg::DATA_W-1:0]     ssram_data_i,
    output logic [soc_bus_pkg::BE_W-1:0]       ssram_be_n_o,
    output logic                               ssram_ce_n_o,
    output logic                               ssram_we_n_o,
    output logic                               ssram_oe_n_o,

    output logic [soc_bus_pkg::DATA_W-1:0]     gpio0_o,
    input  logic [soc_bus_pkg::DATA_W-1:0]     gpio1_i
);
    import soc_bus_pkg::*;

    logic                   ram_rd;
    logic                   ram_wr;
    logic [RAM_ADDR_W-1:0]  ram_address;
    logic [DATA_W-1:0]      ram_wrdata;
    logic [BE_W-1:0]        ram_be;
    logic [DATA_W-1:0]      ram_rddata;
    logic                   ram_busy;
    logic [ROM_IDX_W-1:0]   rom_index;
    logic [DATA_W-1:0]      rom_data;
    logic                   gpio_rd;
    logic                   gpio_wr;
    logic [GPIO_ADDR_W-1:0] gpio_offset;
    logic [DATA_W-1:0]      gpio_wrdata;
    logic [BE_W-1:0]        gpio_be;
    logic [DATA_W-1:0]      gpio_rddata;

    dbus u_dbus (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .bus_read_i       (bus_read_i),
        .bus_write_i      (bus_write_i),
        .bus_address_i    (bus_address_i),
        .bus_wrdata_i     (bus_wrdata_i),
        .bus_byteenable_i (bus_byteenable_i),
        .bus_rddata_o     (bus_rddata_o),
        .bus_stall_o      (bus_stall_o),
        .ram_rd_o         (ram_rd),
        .ram_wr_o         (ram_wr),
        .ram_address_o    (ram_address),
        .ram_wrdata_o     (ram_wrdata),
        .ram_be_o         (ram_be),
        .ram_rddata_i     (ram_rddata),
        .ram_busy_i       (ram_busy),
        .rom_index_o      (rom_index),
        .rom_data_i       (rom_data),
        .gpio_rd_o        (gpio_rd),
        .gpio_wr_o        (gpio_wr),
        .gpio_offset_o    (gpio_offset),
        .gpio_wrdata_o    (gpio_wrdata),
        .gpio_be_o        (gpio_be),
        .gpio_rddata_i    (gpio_rddata)
    );

    ssram_ctl u_ssram_ctl (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .rd_i            (ram_rd),
        .wr_i            (ram_wr),
        .address_i       (ram_address),
        .wrdata_i        (ram_wrdata),
        .be_i            (ram_be),
        .rddata_o        (ram_rddata),
        .busy_o          (ram_busy),
        .ssram_addr_o    (ssram_addr_o),
        .ssram_data_o    (ssram_data_o),
        .ssram_data_oe_o (ssram_data_oe_o),
        .ssram_data_i    (ssram_data_i),
        .ssram_be_n_o    (ssram_be_n_o),
        .ssram_ce_n_o    (ssram_ce_n_o),
        .ssram_we_n_o    (ssram_we_n_o),
        .ssram_oe_n_o    (ssram_oe_n_o)
    );

    bootrom u_bootrom (
        .clk     (clk),
        .index_i (rom_index),
        .data_o  (rom_data)
    );

    gpio_regs u_gpio_regs (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .rd_i     (gpio_rd),
        .wr_i     (gpio_wr),
        .offset_i (gpio_offset),
        .wrdata_i (gpio_wrdata),
        .be_i     (gpio_be),
        .rddata_o (gpio_rddata),
        .gpio0_o  (gpio0_o),
        .gpio1_i  (gpio1_i)
    );

endmodule

// File: test/ssram_model.sv
module ssram_model (
    input  logic                               clk,
    input  logic [soc_bus_pkg::RAM_ADDR_W-1:0] addr_i,
    input  logic [soc_bus_pkg::DATA_W-1:0]     data_i,
    input  logic                               data_oe_i,
    output logic [soc_bus_pkg::DATA_W-1:0]     data_o,
    input  logic [soc_bus_pkg::BE_W-1:0]       be_n_i,
    input  logic                               ce_n_i,
    input  logic                               we_n_i,
    input  logic                               oe_n_i
);
    import soc_bus_pkg::*;

    localparam int WORDS  = 1024;
    localparam int WIDX_W = 10;

    logic [DATA_W-1:0] mem [WORDS];
    logic [WIDX_W-1:0] widx;

    assign widx = addr_i[WIDX_W+1:2];

    // Every word starts out with a value tied to its own index.
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0101);
        end
        data_o = '0;
    end

    // The controller launches the address on one edge and samples the data
    // SSRAM_RD_LAT edges later, which leaves one register stage in here.
    always @(posedge clk) begin
        if (!ce_n_i && !oe_n_i) begin
            data_o <= mem[widx];
        end
        if (!ce_n_i && !we_n_i && data_oe_i) begin
            for (int b = 0; b < BE_W; b++) begin
                if (!be_n_i[b]) begin
                    mem[widx][b*8 +: 8] <= data_i[b*8 +: 8];
                end
            end
        end
    end

endmodule

// File: test/tb_soc_bus.sv
module tb_soc_bus;
    import soc_bus_pkg::*;

    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 10;
    localparam int          RAM_WIN_W    = 5;
    localparam int          RAM_WINDOW   = 1 << RAM_WIN_W;
    localparam int          RAM_OPS      = 200;
    localparam logic [31:0] RAND_SEED    = 32'h63c3_d67d;
    // About 500 accesses of at most 4 cycles each, doubled.
    localparam int          TIMEOUT_CYCLES = 2 * 4 * 500;

    logic                  clk;
    logic                  rst_n;
    logic                  bus_read;
    logic                  bus_write;
    logic [ADDR_W-1:0]     bus_address;
    logic [DATA_W-1:0]     bus_wrdata;
    logic [BE_W-1:0]       bus_be;
    logic [DATA_W-1:0]     bus_rddata;
    logic                  bus_stall;
    logic [RAM_ADDR_W-1:0] ssram_addr;
    logic [DATA_W-1:0]     ssram_wdata;
    logic                  ssram_data_oe;
    logic [DATA_W-1:0]     ssram_rdata;
    logic [BE_W-1:0]       ssram_be_n;
    logic                  ssram_ce_n;
    logic                  ssram_we_n;
    logic                  ssram_oe_n;
    logic [DATA_W-1:0]     gpio0;
    logic [DATA_W-1:0]     gpio1;

    logic [DATA_W-1:0] ram_shadow [RAM_WINDOW];
    logic [DATA_W-1:0] rom_image [ROM_WORDS];
    logic [DATA_W-1:0] gpio_out_shadow;
    logic [DATA_W-1:0] gpio_in_held;
    string             test_name;
    int                cycle_count = 0;

    soc_bus_top DUT (
        .clk (clk), .rst_n_i (rst_n),
        .bus_read_i (bus_read), .bus_write_i (bus_write),
        .bus_address_i (bus_address), .bus_wrdata_i (bus_wrdata),
        .bus_byteenable_i (bus_be), .bus_rddata_o (bus_rddata), .bus_stall_o (bus_stall),
        .ssram_addr_o (ssram_addr), .ssram_data_o (ssram_wdata),
        .ssram_data_oe_o (ssram_data_oe), .ssram_data_i (ssram_rdata),
        .ssram_be_n_o (ssram_be_n), .ssram_ce_n_o (ssram_ce_n),
        .ssram_we_n_o (ssram_we_n), .ssram_oe_n_o (ssram_oe_n),
        .gpio0_o (gpio0), .gpio1_i (gpio1)
    );

    ssram_model u_ssram (
        .clk (clk), .addr_i (ssram_addr), .data_i (ssram_wdata),
        .data_oe_i (ssram_data_oe), .data_o (ssram_rdata), .be_n_i (ssram_be_n),
        .ce_n_i (ssram_ce_n), .we_n_i (ssram_we_n), .oe_n_i (ssram_oe_n)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %08h, actual %08h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic logic [ADDR_W-1:0] make_addr(input logic [REGION_W-1:0] region,
                                                    input int offset);
        return {region, REGION_LO'(offset)};
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] new_word,
                                                      input logic [BE_W-1:0] be);
        logic [DATA_W-1:0] word;
        word = old_word;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                word[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return word;
    endfunction

    // Writes to the ROM region and to unmapped space leave no trace.
    function automatic void record_write(input logic [ADDR_W-1:0] addr,
                                         input logic [DATA_W-1:0] data,
                                         input logic [BE_W-1:0] be);
        logic [RAM_WIN_W-1:0] idx;
        idx = addr[RAM_WIN_W+1:2];
        if (addr[REGION_HI:REGION_LO] == REGION_RAM) begin
            ram_shadow[idx] = merge_bytes(ram_shadow[idx], data, be);
        end else if (addr[REGION_HI:REGION_LO] == REGION_GPIO &&
                     addr[GPIO_ADDR_W-1:0] == GPIO_OUT_OFS) begin
            gpio_out_shadow = merge_bytes(gpio_out_shadow, data, be);
        end
    endfunction

    function automatic logic [DATA_W-1:0] expect_read(input logic [ADDR_W-1:0] addr);
        logic [GPIO_ADDR_W-1:0] ofs;
        ofs = addr[GPIO_ADDR_W-1:0];
        case (addr[REGION_HI:REGION_LO])
            REGION_RAM:  return ram_shadow[addr[RAM_WIN_W+1:2]];
            REGION_ROM:  return rom_image[addr[ROM_IDX_W+1:2]];
            REGION_GPIO: begin
                if (ofs == GPIO_OUT_OFS) return gpio_out_shadow;
                if (ofs == GPIO_IN_OFS) return gpio_in_held;
                return '0;
            end
            default:     return '0;
        endcase
    endfunction

    function automatic int expect_stall(input logic is_write, input logic [ADDR_W-1:0] addr);
        case (addr[REGION_HI:REGION_LO])
            REGION_RAM: return is_write ? 1 : SSRAM_RD_LAT + 1;
            REGION_ROM: return is_write ? 0 : 1;
            default:    return 0;
        endcase
    endfunction

    task automatic run_access(input logic is_write, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data, input logic [BE_W-1:0] be);
        int stalls;
        stalls      = 0;
        bus_read    = ~is_write;
        bus_write   = is_write;
        bus_address = addr;
        bus_wrdata  = data;
        bus_be      = be;
        @(negedge clk);
        while (bus_stall) begin
            stalls++;
            @(negedge clk);
        end
        check_value({test_name, " stall"}, 32'(expect_stall(is_write, addr)), 32'(stalls));
        @(posedge clk);
        #1;
        bus_read  = 1'b0;
        bus_write = 1'b0;
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [BE_W-1:0] be);
        run_access(1'b1, addr, data, be);
    endtask

    task automatic read_word(input logic [ADDR_W-1:0] addr);
        run_access(1'b0, addr, '0, '0);
    endtask

    // Completed accesses are seen mid-cycle, where the bus outputs are settled.
    always @(negedge clk) begin
        if (rst_n && bus_read && !bus_stall) begin
            check_value(test_name, expect_read(bus_address), bus_rddata);
        end
        if (rst_n && bus_write && !bus_stall) begin
            record_write(bus_address, bus_wrdata, bus_be);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   be;
        void'($urandom(RAND_SEED));
        $readmemh("boot.hex", rom_image);
        rst_n           = 1'b0;
        bus_read        = 1'b0;
        bus_write       = 1'b0;
        bus_address     = '0;
        bus_wrdata      = '0;
        bus_be          = '0;
        gpio1           = '0;
        gpio_out_shadow = '0;
        gpio_in_held    = '0;
        test_name       = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("reset stall", '0, 32'(bus_stall));
        check_value("reset gpio0", '0, gpio0);
        check_value("reset sram strobes", 32'h7, 32'({ssram_ce_n, ssram_we_n, ssram_oe_n}));
        @(posedge clk);
        #1;

        // Full words first, so that every later partial write merges into known data.
        test_name = "ram_fill";
        for (int i = 0; i < RAM_WINDOW; i++) begin
            write_word(make_addr(REGION_RAM, i * 4), $urandom, '1);
        end
        test_name = "ram_random";
        for (int n = 0; n < RAM_OPS; n++) begin
            addr = make_addr(REGION_RAM, 4 * int'($urandom_range(RAM_WINDOW - 1)));
            be   = ($urandom_range(1) == 0) ? '1 : BE_W'($urandom);
            write_word(addr, $urandom, be);
            read_word(addr);
        end

        test_name = "rom_read";
        for (int i = 0; i < ROM_WORDS; i++) begin
            read_word(make_addr(REGION_ROM, i * 4));
        end
        test_name = "rom_write";
        write_word(make_addr(REGION_ROM, 12), ~rom_image[3], '1);
        test_name = "rom_reread";
        for (int i = 0; i < ROM_WORDS; i++) begin
            read_word(make_addr(REGION_ROM, i * 4));
        end

        test_name = "gpio_out";
        repeat (8) begin
            write_word(make_addr(REGION_GPIO, int'(GPIO_OUT_OFS)), $urandom, BE_W'($urandom));
            check_value("gpio_out pins", gpio_out_shadow, gpio0);
            read_word(make_addr(REGION_GPIO, int'(GPIO_OUT_OFS)));
        end
        test_name = "gpio_in";
        repeat (4) begin
            gpio1        = $urandom;
            gpio_in_held = gpio1;
            repeat (3) @(posedge clk);
            #1;
            read_word(make_addr(REGION_GPIO, int'(GPIO_IN_OFS)));
        end
        read_word(make_addr(REGION_GPIO, 8));

        test_name = "unmapped";
        for (int r = 3; r < 16; r++) begin
            read_word(make_addr(REGION_W'(r), int'($urandom)));
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: soc_bus.f
rtl/soc_bus_pkg.sv
rtl/dbus.sv
rtl/ssram_ctl.sv
rtl/bootrom.sv
rtl/gpio_regs.sv
rtl/soc_bus_top.sv
test/ssram_model.sv
test/tb_soc_bus.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir
{ verilator --binary --timing --assert --top-module tb_soc_bus -f soc_bus.f &&
    ./obj_dir/Vtb_soc_bus; } > "$LOG" 2>&1 || echo "Simulation FAILED" >> "$LOG"

grep -q "Simulation FAILED" "$LOG" && { echo "FAIL, see $LOG"; exit 1; }
echo "PASS"
exit 0

// File: boot.hex
// Boot ROM image: one 32-bit word per line, word indices 0 to 15.
3c1d1000
27bdfff0
afbf000c
3c080000
25080040
3c092000
ad280000
8d2a0004
114a0003
00000000
0c000010
00000000
08000004
00000000
03e00008
24020001
